//--- verilog/sram_config.svh
// Widths and region bases for the shared SRAM; region plus offset must fill SRAM_ADDR_W bits.
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// Microcode store, one word spans two SRAM locations.
`define MCR_ADDR_W 14
`define MCR_DATA_W 49

// Main memory and video memory windows.
`define SDRAM_ADDR_W 22
`define VRAM_ADDR_W 15
`define CLIENT_DATA_W 32

// Physical SRAM, two 16-bit chips side by side.
`define SRAM_ADDR_W 18
`define SRAM_DQ_W 16

// Top address bits of each region.
`define MCR_REGION 3'b010
`define SDRAM_REGION 2'b00
`define VRAM_REGION 3'b110

`endif

//--- verilog/mem_client_pkg.sv
// Client-side types only; widths come from sram_config.svh and byte lanes are not modeled.
`include "sram_config.svh"

package mem_client_pkg;

   // Which client owns an SRAM cycle.
   typedef enum logic [1:0] {
      client_mcr   = 2'd0,
      client_sdram = 2'd1,
      client_vram  = 2'd2
   } client_e;

   // Direction of a pending access.
   typedef enum logic {
      acc_read  = 1'b0,
      acc_write = 1'b1
   } access_e;

   // Full microcode word.
   typedef logic [`MCR_DATA_W-1:0] mcr_word_t;

   // Data word of the sdram and vram windows.
   typedef logic [`CLIENT_DATA_W-1:0] client_word_t;

   // Client address types, also the type parameter of client_slot.
   typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;
   typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;

endpackage

//--- verilog/sram_bus_pkg.sv
// SRAM-side types; the sequencer state encoding is fixed at four bits with idle at zero.
`include "sram_config.svh"

package sram_bus_pkg;

   // Sequencer states, one SRAM cycle each.
   typedef enum logic [3:0] {
      seq_idle     = 4'd0,
      seq_mcr_rd1  = 4'd1,
      seq_mcr_rd2  = 4'd2,
      seq_mcr_wr1  = 4'd3,
      seq_mcr_wr2  = 4'd4,
      seq_sdram_rd = 4'd5,
      seq_sdram_wr = 4'd6,
      seq_vram_rd  = 4'd7,
      seq_vram_wr  = 4'd8
   } seq_state_e;

   // Shared address bus of both chips.
   typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

   // Data of one chip.
   typedef logic [`SRAM_DQ_W-1:0] sram_half_t;

endpackage

//--- verilog/mem_req_if.sv
// One pending client access; addr is an offset below the client region, not a full SRAM address.
`include "sram_config.svh"

interface mem_req_if;

   // Held high until the cycle in which served is seen.
   logic pending;
   mem_client_pkg::access_e kind;

   // Offset sized to sit under the 2-bit sdram region.
   logic [`SRAM_ADDR_W-$bits(`SDRAM_REGION)-1:0] addr;
   mem_client_pkg::client_word_t wdata;

   // High for the one cycle of the SRAM access.
   logic served;

   modport slot (
      output pending,
      output kind,
      output addr,
      output wdata,
      input  served
   );

   modport seq (
      input  pending,
      input  kind,
      input  addr,
      input  wdata,
      output served
   );

endinterface

//--- verilog/client_slot.sv
// Holds one request until served; a request pulse that arrives while pending is dropped.
`include "sram_config.svh"

module client_slot #(
   parameter type ADDR_T = mem_client_pkg::sdram_addr_t
) (
   input  logic clk,
   input  logic reset,
   input  logic req,
   input  logic write,
   input  ADDR_T addr,
   input  mem_client_pkg::client_word_t wdata,
   output logic busy,
   mem_req_if.slot bus
);

   localparam int ADDR_BITS = $bits(ADDR_T);
   localparam int OFF_W = `SRAM_ADDR_W - $bits(`SDRAM_REGION);

   logic [OFF_W-1:0] offset;
   logic accept;

   // Wide addresses keep their low bits, narrow ones are zero extended.
   generate
      if (ADDR_BITS >= OFF_W) begin : g_trunc
         assign offset = addr[OFF_W-1:0];
      end else begin : g_extend
         assign offset = {{(OFF_W-ADDR_BITS){1'b0}}, addr};
      end
   endgenerate

   assign accept = (req || write) && !bus.pending;
   assign busy = bus.pending;

   always_ff @(posedge clk) begin
      if (reset) begin
         bus.pending <= 1'b0;
      end else if (bus.served) begin
         bus.pending <= 1'b0;
      end else if (accept) begin
         bus.pending <= 1'b1;
      end
   end

   // Request payload, captured with the pulse.
   always_ff @(posedge clk) begin
      if (accept) begin
         bus.kind  <= write ? mem_client_pkg::acc_write : mem_client_pkg::acc_read;
         bus.addr  <= offset;
         bus.wdata <= wdata;
      end
   end

   // Client protocol: a new pulse must wait for ready or done.
   a_no_req_while_pending: assert property (
      @(posedge clk) disable iff (reset)
      bus.pending |-> !(req || write)
   ) else $error("client request while previous access still pending");

endmodule

//--- verilog/ram_controller.sv
// Fixed-cycle sequencer; mcr_addr and mcr_data_in must stay stable through the whole microcode cycle.
`include "sram_config.svh"

module ram_controller (
   input  logic clk,
   input  logic reset,
   input  logic fetch,
   input  logic [`MCR_ADDR_W-1:0] mcr_addr,
   input  logic mcr_write,
   input  mem_client_pkg::mcr_word_t mcr_data_in,
   mem_req_if.seq sdram_bus,
   mem_req_if.seq vram_bus,
   output sram_bus_pkg::seq_state_e state,
   output logic mcr_ready,
   output logic mcr_done,
   output sram_bus_pkg::sram_addr_t sram_a,
   output logic sram_oe_n,
   output logic sram_we_n,
   output logic sram1_ce_n,
   output logic sram1_ub_n,
   output logic sram1_lb_n,
   output logic sram2_ce_n,
   output logic sram2_ub_n,
   output logic sram2_lb_n,
   output sram_bus_pkg::sram_half_t sram1_wdata,
   output sram_bus_pkg::sram_half_t sram2_wdata,
   output logic drive
);

   sram_bus_pkg::seq_state_e next_state;
   sram_bus_pkg::seq_state_e client_state;
   mem_client_pkg::client_e pick;
   mem_client_pkg::client_e owner;
   mem_client_pkg::access_e pick_kind;
   logic client_go;
   logic half;
   logic is_read;
   logic is_write;
   logic active;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sram_bus_pkg::seq_idle;
      end else begin
         state <= next_state;
      end
   end

   // Client choice, sdram ahead of vram.
   always_comb begin
      client_go = sdram_bus.pending || vram_bus.pending;
      pick = sdram_bus.pending ? mem_client_pkg::client_sdram : mem_client_pkg::client_vram;
      pick_kind = sdram_bus.pending ? sdram_bus.kind : vram_bus.kind;
      if (pick == mem_client_pkg::client_sdram) begin
         client_state = (pick_kind == mem_client_pkg::acc_write) ?
                        sram_bus_pkg::seq_sdram_wr : sram_bus_pkg::seq_sdram_rd;
      end else begin
         client_state = (pick_kind == mem_client_pkg::acc_write) ?
                        sram_bus_pkg::seq_vram_wr : sram_bus_pkg::seq_vram_rd;
      end
   end

   always_comb begin
      next_state = sram_bus_pkg::seq_idle;
      case (state)
         sram_bus_pkg::seq_idle: begin
            if (fetch) begin
               next_state = sram_bus_pkg::seq_mcr_rd1;
            end else if (client_go) begin
               next_state = client_state;
            end
         end
         sram_bus_pkg::seq_mcr_rd1: next_state = sram_bus_pkg::seq_mcr_rd2;
         // One extra access per fetch, microcode write first.
         sram_bus_pkg::seq_mcr_rd2: begin
            if (mcr_write) begin
               next_state = sram_bus_pkg::seq_mcr_wr1;
            end else if (client_go) begin
               next_state = client_state;
            end
         end
         sram_bus_pkg::seq_mcr_wr1: next_state = sram_bus_pkg::seq_mcr_wr2;
         default: next_state = sram_bus_pkg::seq_idle;
      endcase
   end

   // Owner of the current cycle.
   always_comb begin
      case (state)
         sram_bus_pkg::seq_sdram_rd, sram_bus_pkg::seq_sdram_wr:
            owner = mem_client_pkg::client_sdram;
         sram_bus_pkg::seq_vram_rd, sram_bus_pkg::seq_vram_wr:
            owner = mem_client_pkg::client_vram;
         default:
            owner = mem_client_pkg::client_mcr;
      endcase
   end

   assign half = (state == sram_bus_pkg::seq_mcr_rd2) || (state == sram_bus_pkg::seq_mcr_wr2);
   assign is_read = (state == sram_bus_pkg::seq_mcr_rd1) || (state == sram_bus_pkg::seq_mcr_rd2) ||
                    (state == sram_bus_pkg::seq_sdram_rd) || (state == sram_bus_pkg::seq_vram_rd);
   assign is_write = (state == sram_bus_pkg::seq_mcr_wr1) || (state == sram_bus_pkg::seq_mcr_wr2) ||
                     (state == sram_bus_pkg::seq_sdram_wr) || (state == sram_bus_pkg::seq_vram_wr);
   assign active = (state != sram_bus_pkg::seq_idle);

   always_comb begin
      case (owner)
         mem_client_pkg::client_sdram: sram_a = {`SDRAM_REGION, sdram_bus.addr};
         mem_client_pkg::client_vram:  sram_a = {`VRAM_REGION, vram_bus.addr[`VRAM_ADDR_W-1:0]};
         default:                      sram_a = {`MCR_REGION, mcr_addr, half};
      endcase
   end

   // Word split: bit 48 and bits 47..32 first, then the low 32 bits.
   always_comb begin
      sram1_wdata = '0;
      sram2_wdata = '0;
      case (state)
         sram_bus_pkg::seq_mcr_wr1: begin
            sram1_wdata = {{(`SRAM_DQ_W-1){1'b0}}, mcr_data_in[48]};
            sram2_wdata = mcr_data_in[47:32];
         end
         sram_bus_pkg::seq_mcr_wr2: begin
            sram1_wdata = mcr_data_in[31:16];
            sram2_wdata = mcr_data_in[15:0];
         end
         sram_bus_pkg::seq_sdram_wr: begin
            sram1_wdata = sdram_bus.wdata[31:16];
            sram2_wdata = sdram_bus.wdata[15:0];
         end
         sram_bus_pkg::seq_vram_wr: begin
            sram1_wdata = vram_bus.wdata[31:16];
            sram2_wdata = vram_bus.wdata[15:0];
         end
         default: ;
      endcase
   end

   assign sram_oe_n = !is_read;
   assign sram_we_n = !is_write;
   assign drive = is_write;

   // All byte lanes of both chips are on for any cycle.
   assign sram1_ce_n = !active;
   assign sram1_ub_n = !active;
   assign sram1_lb_n = !active;
   assign sram2_ce_n = !active;
   assign sram2_ub_n = !active;
   assign sram2_lb_n = !active;

   assign mcr_ready = (state == sram_bus_pkg::seq_mcr_rd2);
   assign mcr_done = (state == sram_bus_pkg::seq_mcr_wr1);

   assign sdram_bus.served = (owner == mem_client_pkg::client_sdram);
   assign vram_bus.served = (owner == mem_client_pkg::client_vram);

   a_oe_we_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      !(!sram_oe_n && !sram_we_n)
   ) else $error("output enable and write enable both active");

   // Data goes out only for a microcode write or for a slot that holds a write.
   a_drive_only_on_write: assert property (
      @(posedge clk) disable iff (reset)
      drive |-> (sdram_bus.served ? (sdram_bus.kind == mem_client_pkg::acc_write) :
                 vram_bus.served ? (vram_bus.kind == mem_client_pkg::acc_write) :
                 ((state == sram_bus_pkg::seq_mcr_wr1) ||
                  (state == sram_bus_pkg::seq_mcr_wr2)))
   ) else $error("data driven outside a write cycle");

   // A slot is only served while it holds a request.
   a_served_needs_pending: assert property (
      @(posedge clk) disable iff (reset)
      (!sdram_bus.served || sdram_bus.pending) && (!vram_bus.served || vram_bus.pending)
   ) else $error("client cycle without a pending request");

endmodule

//--- verilog/read_assemble.sv
// Read results are valid only in their read state and zero otherwise; no output is registered.
`include "sram_config.svh"

module read_assemble (
   input  logic clk,
   input  logic reset,
   input  sram_bus_pkg::seq_state_e state,
   input  sram_bus_pkg::sram_half_t sram1_rdata,
   input  sram_bus_pkg::sram_half_t sram2_rdata,
   output mem_client_pkg::mcr_word_t mcr_data_out,
   output mem_client_pkg::client_word_t sdram_rdata,
   output mem_client_pkg::client_word_t vram_rdata
);

   // Upper part of the microcode word, read in the first half cycle.
   localparam int HOLD_W = `MCR_DATA_W - `CLIENT_DATA_W;

   logic [HOLD_W-1:0] hold;
   mem_client_pkg::client_word_t pair;
   mem_client_pkg::client_e rd_client;
   logic rd_valid;

   assign pair = {sram1_rdata, sram2_rdata};

   always_ff @(posedge clk) begin
      if (state == sram_bus_pkg::seq_mcr_rd1) begin
         hold <= pair[HOLD_W-1:0];
      end
   end

   // Which client the bus data belongs to this cycle.
   always_comb begin
      rd_valid = 1'b1;
      case (state)
         sram_bus_pkg::seq_mcr_rd2:  rd_client = mem_client_pkg::client_mcr;
         sram_bus_pkg::seq_sdram_rd: rd_client = mem_client_pkg::client_sdram;
         sram_bus_pkg::seq_vram_rd:  rd_client = mem_client_pkg::client_vram;
         default: begin
            rd_client = mem_client_pkg::client_mcr;
            rd_valid = 1'b0;
         end
      endcase
   end

   assign mcr_data_out = (rd_valid && rd_client == mem_client_pkg::client_mcr) ?
                         {hold, pair} : '0;
   assign sdram_rdata = (rd_valid && rd_client == mem_client_pkg::client_sdram) ? pair : '0;
   assign vram_rdata = (rd_valid && rd_client == mem_client_pkg::client_vram) ? pair : '0;

   // The held half must come from the cycle just before.
   a_rd2_after_rd1: assert property (
      @(posedge clk) disable iff (reset)
      (state == sram_bus_pkg::seq_mcr_rd2) |-> ($past(state) == sram_bus_pkg::seq_mcr_rd1)
   ) else $error("second microcode half read without the first");

endmodule

//--- verilog/sram_subsystem.sv
// Top level; SRAM data pins are split into read and write buses, written while drive is high.
`include "sram_config.svh"

module sram_subsystem (
   input  logic clk,
   input  logic reset,
   // Microcode port.
   input  logic fetch,
   input  logic [`MCR_ADDR_W-1:0] mcr_addr,
   input  logic mcr_write,
   input  mem_client_pkg::mcr_word_t mcr_data_in,
   output mem_client_pkg::mcr_word_t mcr_data_out,
   output logic mcr_ready,
   output logic mcr_done,
   // Main memory window.
   input  logic sdram_req,
   input  logic sdram_write,
   input  mem_client_pkg::sdram_addr_t sdram_addr,
   input  mem_client_pkg::client_word_t sdram_wdata,
   output mem_client_pkg::client_word_t sdram_rdata,
   output logic sdram_ready,
   output logic sdram_done,
   // Video memory window.
   input  logic vram_req,
   input  logic vram_write,
   input  mem_client_pkg::vram_addr_t vram_addr,
   input  mem_client_pkg::client_word_t vram_wdata,
   output mem_client_pkg::client_word_t vram_rdata,
   output logic vram_ready,
   output logic vram_done,
   // SRAM pins.
   output sram_bus_pkg::sram_addr_t sram_a,
   output logic sram_oe_n,
   output logic sram_we_n,
   output logic sram1_ce_n,
   output logic sram1_ub_n,
   output logic sram1_lb_n,
   output logic sram2_ce_n,
   output logic sram2_ub_n,
   output logic sram2_lb_n,
   output sram_bus_pkg::sram_half_t sram1_wdata,
   output sram_bus_pkg::sram_half_t sram2_wdata,
   input  sram_bus_pkg::sram_half_t sram1_rdata,
   input  sram_bus_pkg::sram_half_t sram2_rdata,
   output logic drive
);

   sram_bus_pkg::seq_state_e state;

   mem_req_if sdram_bus ();
   mem_req_if vram_bus ();

   client_slot #(
      .ADDR_T(mem_client_pkg::sdram_addr_t)
   ) i_sdram_slot (
      .clk(clk),
      .reset(reset),
      .req(sdram_req),
      .write(sdram_write),
      .addr(sdram_addr),
      .wdata(sdram_wdata),
      .busy(),
      .bus(sdram_bus)
   );

   client_slot #(
      .ADDR_T(mem_client_pkg::vram_addr_t)
   ) i_vram_slot (
      .clk(clk),
      .reset(reset),
      .req(vram_req),
      .write(vram_write),
      .addr(vram_addr),
      .wdata(vram_wdata),
      .busy(),
      .bus(vram_bus)
   );

   ram_controller i_ram_controller (
      .clk(clk),
      .reset(reset),
      .fetch(fetch),
      .mcr_addr(mcr_addr),
      .mcr_write(mcr_write),
      .mcr_data_in(mcr_data_in),
      .sdram_bus(sdram_bus),
      .vram_bus(vram_bus),
      .state(state),
      .mcr_ready(mcr_ready),
      .mcr_done(mcr_done),
      .sram_a(sram_a),
      .sram_oe_n(sram_oe_n),
      .sram_we_n(sram_we_n),
      .sram1_ce_n(sram1_ce_n),
      .sram1_ub_n(sram1_ub_n),
      .sram1_lb_n(sram1_lb_n),
      .sram2_ce_n(sram2_ce_n),
      .sram2_ub_n(sram2_ub_n),
      .sram2_lb_n(sram2_lb_n),
      .sram1_wdata(sram1_wdata),
      .sram2_wdata(sram2_wdata),
      .drive(drive)
   );

   read_assemble i_read_assemble (
      .clk(clk),
      .reset(reset),
      .state(state),
      .sram1_rdata(sram1_rdata),
      .sram2_rdata(sram2_rdata),
      .mcr_data_out(mcr_data_out),
      .sdram_rdata(sdram_rdata),
      .vram_rdata(vram_rdata)
   );

   // Client completions, one cycle each, straight from the sequencer state.
   assign sdram_ready = (state == sram_bus_pkg::seq_sdram_rd);
   assign sdram_done = (state == sram_bus_pkg::seq_sdram_wr);
   assign vram_ready = (state == sram_bus_pkg::seq_vram_rd);
   assign vram_done = (state == sram_bus_pkg::seq_vram_wr);

endmodule

//--- tb/sram_model.sv
// Two 16-bit SRAM chips; reads are combinational, writes land at the rising clock edge, and unwritten words hold an address pattern.
`include "sram_config.svh"

module sram_model (
   input  logic clk,
   input  sram_bus_pkg::sram_addr_t sram_a,
   input  logic sram_oe_n,
   input  logic sram_we_n,
   input  logic sram1_ce_n,
   input  logic sram1_ub_n,
   input  logic sram1_lb_n,
   input  logic sram2_ce_n,
   input  logic sram2_ub_n,
   input  logic sram2_lb_n,
   input  sram_bus_pkg::sram_half_t sram1_wdata,
   input  sram_bus_pkg::sram_half_t sram2_wdata,
   input  logic drive,
   output sram_bus_pkg::sram_half_t sram1_rdata,
   output sram_bus_pkg::sram_half_t sram2_rdata
);

   localparam int DEPTH = 1 << `SRAM_ADDR_W;

   // Chip contents, also read directly by the testbench.
   sram_bus_pkg::sram_half_t mem1 [DEPTH];
   sram_bus_pkg::sram_half_t mem2 [DEPTH];

   // Every address bit takes part in the fill value.
   initial begin
      sram_bus_pkg::sram_addr_t a;
      int i;
      for (i = 0; i < DEPTH; i++) begin
         a = sram_bus_pkg::sram_addr_t'(i);
         mem1[a] = 16'(i) ^ 16'(i >> 2);
         mem2[a] = ~mem1[a];
      end
   end

   always @(posedge clk) begin
      if (!sram_we_n && drive) begin
         if (!sram1_ce_n && !sram1_ub_n) begin
            mem1[sram_a][15:8] <= sram1_wdata[15:8];
         end
         if (!sram1_ce_n && !sram1_lb_n) begin
            mem1[sram_a][7:0] <= sram1_wdata[7:0];
         end
         if (!sram2_ce_n && !sram2_ub_n) begin
            mem2[sram_a][15:8] <= sram2_wdata[15:8];
         end
         if (!sram2_ce_n && !sram2_lb_n) begin
            mem2[sram_a][7:0] <= sram2_wdata[7:0];
         end
      end
   end

   // Outputs read as zero while a chip is deselected.
   assign sram1_rdata = (!sram_oe_n && !sram1_ce_n) ? mem1[sram_a] : '0;
   assign sram2_rdata = (!sram_oe_n && !sram2_ce_n) ? mem2[sram_a] : '0;

endmodule

//--- tb/tb_sram_subsystem.sv
// Table-driven test of the SRAM subsystem; inputs change on the falling edge and outputs are sampled there too.
`include "sram_config.svh"

module tb_sram_subsystem;

   localparam int TIMEOUT = 50;

   typedef enum int {
      op_fetch,
      op_fetch_wr,
      op_sdram_wr,
      op_sdram_rd,
      op_vram_wr,
      op_vram_rd
   } op_e;

   // One table entry; want is valid only with has_exp.
   typedef struct {
      op_e op;
      logic [`SDRAM_ADDR_W-1:0] addr;
      mem_client_pkg::mcr_word_t wdata;
      logic has_exp;
      mem_client_pkg::mcr_word_t want;
   } step_t;

   logic clk;
   logic reset;
   logic fetch;
   logic [`MCR_ADDR_W-1:0] mcr_addr;
   logic mcr_write;
   mem_client_pkg::mcr_word_t mcr_data_in;
   mem_client_pkg::mcr_word_t mcr_data_out;
   logic mcr_ready;
   logic mcr_done;
   logic sdram_req;
   logic sdram_write;
   mem_client_pkg::sdram_addr_t sdram_addr;
   mem_client_pkg::client_word_t sdram_wdata;
   mem_client_pkg::client_word_t sdram_rdata;
   logic sdram_ready;
   logic sdram_done;
   logic vram_req;
   logic vram_write;
   mem_client_pkg::vram_addr_t vram_addr;
   mem_client_pkg::client_word_t vram_wdata;
   mem_client_pkg::client_word_t vram_rdata;
   logic vram_ready;
   logic vram_done;
   sram_bus_pkg::sram_addr_t sram_a;
   logic sram_oe_n;
   logic sram_we_n;
   logic sram1_ce_n;
   logic sram1_ub_n;
   logic sram1_lb_n;
   logic sram2_ce_n;
   logic sram2_ub_n;
   logic sram2_lb_n;
   sram_bus_pkg::sram_half_t sram1_wdata;
   sram_bus_pkg::sram_half_t sram2_wdata;
   sram_bus_pkg::sram_half_t sram1_rdata;
   sram_bus_pkg::sram_half_t sram2_rdata;
   logic drive;

   int seed = 77411;
   step_t steps [$];

   // Words written so far, keyed by the offset that reaches the SRAM.
   mem_client_pkg::mcr_word_t mcr_shadow [int];
   mem_client_pkg::client_word_t sdram_shadow [int];
   mem_client_pkg::client_word_t vram_shadow [int];

   sram_subsystem i_sram_subsystem (.*);

   sram_model i_sram_model (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   task automatic give_up(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
      if (got !== want) begin
         give_up($sformatf("Mismatch %s: got %h, expected %h", name, got, want));
      end
   endtask

   function automatic mem_client_pkg::mcr_word_t rand_word();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[`MCR_DATA_W-1:0];
   endfunction

   function automatic logic client_end(input logic vram);
      return vram ? (vram_ready || vram_done) : (sdram_ready || sdram_done);
   endfunction

   // Appends an entry and fills in its expected read data from the shadows.
   task automatic add_step(input op_e op, input logic [`SDRAM_ADDR_W-1:0] addr,
                           input mem_client_pkg::mcr_word_t wdata);
      step_t s;
      int key;
      s.op = op;
      s.addr = addr;
      s.wdata = wdata;
      s.has_exp = 1'b0;
      s.want = '0;
      case (op)
         op_fetch, op_fetch_wr: begin
            key = int'(addr[`MCR_ADDR_W-1:0]);
            if (mcr_shadow.exists(key)) begin
               s.has_exp = 1'b1;
               s.want = mcr_shadow[key];
            end
            if (op == op_fetch_wr) begin
               mcr_shadow[key] = wdata;
            end
         end
         op_sdram_wr: sdram_shadow[int'(addr[15:0])] = wdata[31:0];
         op_vram_wr: vram_shadow[int'(addr[`VRAM_ADDR_W-1:0])] = wdata[31:0];
         op_sdram_rd: begin
            key = int'(addr[15:0]);
            if (sdram_shadow.exists(key)) begin
               s.has_exp = 1'b1;
               s.want = mem_client_pkg::mcr_word_t'(sdram_shadow[key]);
            end
         end
         default: begin
            key = int'(addr[`VRAM_ADDR_W-1:0]);
            if (vram_shadow.exists(key)) begin
               s.has_exp = 1'b1;
               s.want = mem_client_pkg::mcr_word_t'(vram_shadow[key]);
            end
         end
      endcase
      steps.push_back(s);
   endtask

   task automatic build_table();
      // Microcode write, read back, overwrite, and bit 48 set.
      add_step(op_fetch_wr, 22'h000123, rand_word());
      add_step(op_fetch, 22'h000123, '0);
      add_step(op_fetch_wr, 22'h003ffe, rand_word());
      add_step(op_fetch_wr, 22'h000123, rand_word());
      add_step(op_fetch, 22'h000123, '0);
      add_step(op_fetch, 22'h003ffe, '0);
      add_step(op_fetch_wr, 22'h000001, 49'h1_2345_6789_abcd);
      add_step(op_fetch, 22'h000001, '0);
      // Same low offset in both windows; upper sdram bits are not mapped.
      add_step(op_sdram_wr, 22'h2a5678, rand_word());
      add_step(op_vram_wr, 22'h005678, rand_word());
      add_step(op_sdram_rd, 22'h005678, '0);
      add_step(op_vram_rd, 22'h005678, '0);
      add_step(op_sdram_wr, 22'h000010, rand_word());
      add_step(op_vram_wr, 22'h007ff0, rand_word());
      add_step(op_sdram_rd, 22'h3f0010, '0);
      add_step(op_vram_rd, 22'h007ff0, '0);
   endtask

   task automatic check_idle();
      compare("strobes", 64'({sram_oe_n, sram_we_n, sram1_ce_n, sram1_ub_n, sram1_lb_n,
                              sram2_ce_n, sram2_ub_n, sram2_lb_n}), 64'hff);
      compare("idle outputs", 64'({drive, sdram_ready, sdram_done, vram_ready, vram_done,
                                   mcr_ready, mcr_done}), 64'h0);
   endtask

   task automatic do_fetch(input step_t s);
      sram_bus_pkg::sram_addr_t base;
      int n;
      @(negedge clk);
      fetch = 1'b1;
      mcr_addr = s.addr[`MCR_ADDR_W-1:0];
      mcr_write = (s.op == op_fetch_wr);
      mcr_data_in = s.wdata;
      // Taken at the next rising edge that finds the sequencer idle.
      n = 0;
      while (!sram1_ce_n && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!sram1_ce_n) begin
         give_up("sequencer never returned to idle to take the fetch");
      end
      @(negedge clk);
      fetch = 1'b0;
      n = 1;
      while (!mcr_ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!mcr_ready) begin
         give_up("no mcr_ready after an accepted fetch");
      end
      compare("mcr_ready latency", 64'(n), 64'd2);
      if (s.has_exp) begin
         compare("mcr_data_out", 64'(mcr_data_out), 64'(s.want));
      end
      if (s.op == op_fetch_wr) begin
         @(negedge clk);
         compare("mcr_done", 64'(mcr_done), 64'd1);
         mcr_write = 1'b0;
         // Both halves are stored once wr2 has ended.
         @(negedge clk);
         @(negedge clk);
         base = {`MCR_REGION, s.addr[`MCR_ADDR_W-1:0], 1'b0};
         compare("sram1 mcr half 0", 64'(i_sram_model.mem1[base]), 64'(s.wdata[48]));
         compare("sram2 mcr half 0", 64'(i_sram_model.mem2[base]), 64'(s.wdata[47:32]));
         base[0] = 1'b1;
         compare("sram1 mcr half 1", 64'(i_sram_model.mem1[base]), 64'(s.wdata[31:16]));
         compare("sram2 mcr half 1", 64'(i_sram_model.mem2[base]), 64'(s.wdata[15:0]));
      end
   endtask

   task automatic client_access(input step_t s);
      sram_bus_pkg::sram_addr_t loc;
      string who;
      logic vram;
      logic wr;
      int n;
      vram = (s.op == op_vram_wr) || (s.op == op_vram_rd);
      wr = (s.op == op_sdram_wr) || (s.op == op_vram_wr);
      @(negedge clk);
      if (vram) begin
         who = "vram";
         vram_req = !wr;
         vram_write = wr;
         vram_addr = s.addr[`VRAM_ADDR_W-1:0];
         vram_wdata = s.wdata[31:0];
         loc = {`VRAM_REGION, s.addr[`VRAM_ADDR_W-1:0]};
      end else begin
         who = "sdram";
         sdram_req = !wr;
         sdram_write = wr;
         sdram_addr = s.addr;
         sdram_wdata = s.wdata[31:0];
         loc = {`SDRAM_REGION, s.addr[15:0]};
      end
      @(negedge clk);
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      vram_req = 1'b0;
      vram_write = 1'b0;
      n = 1;
      while (!client_end(vram) && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!client_end(vram)) begin
         give_up({who, " access got neither ready nor done"});
      end
      compare({who, " latency at least two"}, 64'(n >= 2), 64'd1);
      if (wr) begin
         compare({who, "_done"}, 64'(vram ? vram_done : sdram_done), 64'd1);
         @(negedge clk);
         compare({who, " sram1 word"}, 64'(i_sram_model.mem1[loc]), 64'(s.wdata[31:16]));
         compare({who, " sram2 word"}, 64'(i_sram_model.mem2[loc]), 64'(s.wdata[15:0]));
      end else begin
         compare({who, "_ready"}, 64'(vram ? vram_ready : sdram_ready), 64'd1);
         if (s.has_exp) begin
            compare({who, "_rdata"}, 64'(vram ? vram_rdata : sdram_rdata), 64'(s.want));
         end
      end
   endtask

   // Fetch held with a microcode write and both clients pending at once.
   // Event codes are 1 ready, 2 done, 3 sdram, 4 vram.
   task automatic contention_test();
      mem_client_pkg::mcr_word_t word;
      logic [63:0] order;
      logic written;
      int n;
      word = rand_word();
      order = '0;
      written = 1'b0;
      @(negedge clk);
      fetch = 1'b1;
      mcr_addr = 14'h0200;
      mcr_write = 1'b1;
      mcr_data_in = word;
      sdram_req = 1'b1;
      sdram_addr = 22'h000010;
      vram_req = 1'b1;
      vram_addr = 15'h7ff0;
      n = 0;
      while (!vram_ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
         sdram_req = 1'b0;
         vram_req = 1'b0;
         if (mcr_ready) begin
            order = {order[59:0], 4'h1};
            if (written) begin
               compare("mcr_data_out", 64'(mcr_data_out), 64'(word));
            end
         end
         if (mcr_done) begin
            order = {order[59:0], 4'h2};
            written = 1'b1;
            mcr_write = 1'b0;
         end
         if (sdram_ready) begin
            order = {order[59:0], 4'h3};
            compare("sdram_rdata", 64'(sdram_rdata), 64'(sdram_shadow['h10]));
         end
         if (vram_ready) begin
            order = {order[59:0], 4'h4};
            compare("vram_rdata", 64'(vram_rdata), 64'(vram_shadow['h7ff0]));
         end
      end
      fetch = 1'b0;
      if (!vram_ready) begin
         give_up("vram request was not served while fetch was held");
      end
      compare("service order", order, 64'h121314);
      mcr_shadow['h200] = word;
   endtask

   initial begin
      reset = 1'b1;
      fetch = 1'b0;
      mcr_addr = '0;
      mcr_write = 1'b0;
      mcr_data_in = '0;
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      sdram_addr = '0;
      sdram_wdata = '0;
      vram_req = 1'b0;
      vram_write = 1'b0;
      vram_addr = '0;
      vram_wdata = '0;
      build_table();
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_idle();
      foreach (steps[i]) begin
         case (steps[i].op)
            op_fetch, op_fetch_wr: do_fetch(steps[i]);
            default: client_access(steps[i]);
         endcase
      end
      contention_test();
      @(negedge clk);
      check_idle();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- list.f
+incdir+verilog
verilog/mem_client_pkg.sv
verilog/sram_bus_pkg.sv
verilog/mem_req_if.sv
verilog/client_slot.sv
verilog/ram_controller.sv
verilog/read_assemble.sv
verilog/sram_subsystem.sv
tb/sram_model.sv
tb/tb_sram_subsystem.sv

//--- Makefile
SIM = obj_dir/Vtb_sram_subsystem
SRCS = list.f $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_sram_subsystem -f list.f

# The exit status of the simulator is the result of the run.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
